//--- source/bridge_pkg.sv
package bridge_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    // cache line geometry
    localparam int LINE_WORDS    = 4;
    localparam int LINE_W        = LINE_WORDS * DATA_W;
    // address bits inside one line, 16 bytes
    localparam int LINE_OFFSET_W = 4;

    // beat index and axi arlen share this width
    localparam int BEAT_W = 8;

    // axi ids, one per requester
    localparam int AXI_ID_W = 4;
    localparam logic [AXI_ID_W-1:0] ID_INST = 4'd0;
    localparam logic [AXI_ID_W-1:0] ID_DATA = 4'd1;

    // bridge sequencing states
    typedef enum logic [2:0] {
        // waiting for a requester
        ST_IDLE = 3'd0,
        // read address offered
        ST_AR   = 3'd1,
        // collecting read beats
        ST_R    = 3'd2,
        // write address and data offered together
        ST_AW_W = 3'd3,
        // waiting for the write response
        ST_B    = 3'd4
    } bridge_state_e;

    // granted request kind
    typedef enum logic [1:0] {
        // four word burst for the instruction side
        OP_INST_LINE  = 2'd0,
        // single word read for the data side
        OP_DATA_READ  = 2'd1,
        // single word strobed write
        OP_DATA_WRITE = 2'd2
    } req_op_e;

endpackage

//--- source/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
    input  logic                          clk,
    input  logic                          reset,
    // ar handshake restarts the burst
    input  logic                          clear_i,
    // one pulse per accepted r beat
    input  logic                          beat_i,
    // latched arlen
    input  logic [bridge_pkg::BEAT_W-1:0] len_i,
    output logic [bridge_pkg::BEAT_W-1:0] beat_idx_o,
    output logic                          last_beat_o
);

    import bridge_pkg::*;

    logic [BEAT_W-1:0] idx_q;

    always_ff @(posedge clk) begin
        if (reset || clear_i) begin
            idx_q <= '0;
        end else if (beat_i) begin
            // rvalid low leaves the index alone
            idx_q <= idx_q + BEAT_W'(1);
        end
    end

    assign beat_idx_o = idx_q;
    // arlen is beats minus one, so equality marks the last beat
    assign last_beat_o = (idx_q == len_i);

endmodule

//--- source/line_assembler.sv
`timescale 1ns/1ps

module line_assembler (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          beat_i,
    input  logic [bridge_pkg::BEAT_W-1:0] beat_idx_i,
    input  logic [bridge_pkg::DATA_W-1:0] rdata_i,
    output logic [bridge_pkg::LINE_W-1:0] line_o,
    output logic [bridge_pkg::DATA_W-1:0] word0_o
);

    import bridge_pkg::*;

    // one slot per word, slot 0 is the lowest address
    logic [DATA_W-1:0] words_q [LINE_WORDS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            if (reset) begin
                words_q[w] <= '0;
            end else if (beat_i && beat_idx_i == BEAT_W'(w)) begin
                words_q[w] <= rdata_i;
            end
        end
    end

    // flatten slots, word 0 in the low bits
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            line_o[w*DATA_W +: DATA_W] = words_q[w];
        end
    end

    // single word reads always land here
    assign word0_o = words_q[0];

endmodule

//--- source/request_latch.sv
`timescale 1ns/1ps

module request_latch (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            capture_i,
    input  bridge_pkg::req_op_e             grant_op_i,
    // raw requester fields
    input  logic [bridge_pkg::ADDR_W-1:0]   inst_addr_i,
    input  logic [bridge_pkg::ADDR_W-1:0]   data_addr_i,
    input  logic [bridge_pkg::DATA_W-1:0]   data_wdata_i,
    input  logic [bridge_pkg::STRB_W-1:0]   data_wstrb_i,
    // held for the whole transaction
    output bridge_pkg::req_op_e             op_o,
    output logic [bridge_pkg::ADDR_W-1:0]   araddr_o,
    output logic [bridge_pkg::AXI_ID_W-1:0] arid_o,
    output logic [bridge_pkg::BEAT_W-1:0]   arlen_o,
    output logic [bridge_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [bridge_pkg::DATA_W-1:0]   wdata_o,
    output logic [bridge_pkg::STRB_W-1:0]   wstrb_o
);

    import bridge_pkg::*;

    req_op_e             op_q;
    logic [AXI_ID_W-1:0] id_q;
    logic [BEAT_W-1:0]   len_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [STRB_W-1:0]   wstrb_q;

    logic                is_line;

    assign is_line = (grant_op_i == OP_INST_LINE);

    // opcode, id and length
    always_ff @(posedge clk) begin
        if (reset) begin
            op_q  <= OP_INST_LINE;
            id_q  <= ID_INST;
            len_q <= '0;
        end else if (capture_i) begin
            op_q  <= grant_op_i;
            id_q  <= is_line ? ID_INST : ID_DATA;
            // line fill is a LINE_WORDS beat incr burst
            len_q <= is_line ? BEAT_W'(LINE_WORDS - 1) : '0;
        end
    end

    // address and write payload
    always_ff @(posedge clk) begin
        if (capture_i) begin
            // line reads start at the line base
            addr_q  <= is_line ? {inst_addr_i[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}}
                               : data_addr_i;
            wdata_q <= data_wdata_i;
            wstrb_q <= data_wstrb_i;
        end
    end

    assign op_o     = op_q;
    assign araddr_o = addr_q;
    assign arid_o   = id_q;
    assign arlen_o  = len_q;
    // writes only come from the data side, address unchanged
    assign awaddr_o = addr_q;
    assign wdata_o  = wdata_q;
    assign wstrb_o  = wstrb_q;

endmodule

//--- source/bridge_fsm.sv
`timescale 1ns/1ps

module bridge_fsm (
    input  logic                clk,
    input  logic                reset,
    // requester side
    input  logic                inst_req_i,
    input  logic                data_req_i,
    input  logic                data_we_i,
    // axi handshakes seen from the slave
    input  logic                arready_i,
    input  logic                rvalid_i,
    input  logic                awready_i,
    input  logic                wready_i,
    input  logic                bvalid_i,
    // from beat counter and request latch
    input  logic                last_beat_i,
    input  bridge_pkg::req_op_e op_i,
    // to request latch
    output logic                capture_o,
    output bridge_pkg::req_op_e grant_op_o,
    // axi valids and readies
    output logic                arvalid_o,
    output logic                rready_o,
    output logic                awvalid_o,
    output logic                wvalid_o,
    output logic                bready_o,
    // to beat counter and line assembler
    output logic                burst_start_o,
    output logic                beat_accept_o,
    // completion pulses
    output logic                inst_done_o,
    output logic                data_done_o
);

    import bridge_pkg::*;

    bridge_state_e state_q;
    bridge_state_e state_d;

    // aw and w finish independently
    logic aw_done_q;
    logic w_done_q;
    logic aw_fire;
    logic w_fire;
    logic aw_ok;
    logic w_ok;

    logic r_fire;
    logic read_end;
    logic write_end;

    logic inst_done_q;
    logic data_done_q;
    // done cycle, requests are still high here
    logic done_busy;

    assign done_busy = inst_done_q | data_done_q;

    // channel valids follow the state directly
    assign arvalid_o = (state_q == ST_AR);
    assign rready_o  = (state_q == ST_R);
    assign awvalid_o = (state_q == ST_AW_W) && !aw_done_q;
    assign wvalid_o  = (state_q == ST_AW_W) && !w_done_q;
    assign bready_o  = (state_q == ST_B);

    assign aw_fire = awvalid_o && awready_i;
    assign w_fire  = wvalid_o && wready_i;
    assign aw_ok   = aw_done_q || aw_fire;
    assign w_ok    = w_done_q || w_fire;

    assign r_fire    = rready_o && rvalid_i;
    // counter flags the closing beat of the burst
    assign read_end  = r_fire && last_beat_i;
    assign write_end = bready_o && bvalid_i;

    // counter restarts on the ar handshake
    assign burst_start_o = arvalid_o && arready_i;
    assign beat_accept_o = r_fire;

    assign inst_done_o = inst_done_q;
    assign data_done_o = data_done_q;

    // arbitration and next state
    always_comb begin
        state_d    = state_q;
        capture_o  = 1'b0;
        grant_op_o = OP_INST_LINE;
        case (state_q)
            ST_IDLE: begin
                // data side wins a tie
                if (!done_busy && data_req_i) begin
                    capture_o  = 1'b1;
                    grant_op_o = data_we_i ? OP_DATA_WRITE : OP_DATA_READ;
                    state_d    = data_we_i ? ST_AW_W : ST_AR;
                end else if (!done_busy && inst_req_i) begin
                    capture_o  = 1'b1;
                    grant_op_o = OP_INST_LINE;
                    state_d    = ST_AR;
                end
            end
            ST_AR: begin
                if (arready_i) begin
                    state_d = ST_R;
                end
            end
            ST_R: begin
                if (read_end) begin
                    state_d = ST_IDLE;
                end
            end
            ST_AW_W: begin
                // both channels must have gone through
                if (aw_ok && w_ok) begin
                    state_d = ST_B;
                end
            end
            ST_B: begin
                if (write_end) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= ST_IDLE;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
            inst_done_q <= 1'b0;
            data_done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // handshake flags live only while in aw_w
            if (state_q == ST_AW_W && state_d == ST_AW_W) begin
                aw_done_q <= aw_ok;
                w_done_q  <= w_ok;
            end else begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end
            // one cycle pulse, steered by latched opcode
            inst_done_q <= read_end && (op_i == OP_INST_LINE);
            data_done_q <= (read_end && (op_i != OP_INST_LINE)) || write_end;
        end
    end

endmodule

//--- source/mem_bridge_top.sv
`timescale 1ns/1ps

module mem_bridge_top (
    input  logic                            clk,
    input  logic                            reset,
    // instruction requester
    input  logic                            inst_req_i,
    input  logic [bridge_pkg::ADDR_W-1:0]   inst_addr_i,
    output logic [bridge_pkg::LINE_W-1:0]   inst_line_o,
    output logic                            inst_done_o,
    // data requester
    input  logic                            data_req_i,
    input  logic                            data_we_i,
    input  logic [bridge_pkg::ADDR_W-1:0]   data_addr_i,
    input  logic [bridge_pkg::DATA_W-1:0]   data_wdata_i,
    input  logic [bridge_pkg::STRB_W-1:0]   data_wstrb_i,
    output logic [bridge_pkg::DATA_W-1:0]   data_rdata_o,
    output logic                            data_done_o,
    // axi read address
    output logic                            arvalid_o,
    input  logic                            arready_i,
    output logic [bridge_pkg::AXI_ID_W-1:0] arid_o,
    output logic [bridge_pkg::ADDR_W-1:0]   araddr_o,
    output logic [bridge_pkg::BEAT_W-1:0]   arlen_o,
    // axi read data
    input  logic                            rvalid_i,
    output logic                            rready_o,
    input  logic [bridge_pkg::DATA_W-1:0]   rdata_i,
    // axi write address
    output logic                            awvalid_o,
    input  logic                            awready_i,
    output logic [bridge_pkg::ADDR_W-1:0]   awaddr_o,
    // axi write data, single beat
    output logic                            wvalid_o,
    input  logic                            wready_i,
    output logic [bridge_pkg::DATA_W-1:0]   wdata_o,
    output logic [bridge_pkg::STRB_W-1:0]   wstrb_o,
    // axi write response
    input  logic                            bvalid_i,
    output logic                            bready_o
);

    import bridge_pkg::*;

    // fsm to latch
    logic              capture;
    req_op_e           grant_op;
    req_op_e           latched_op;
    // fsm to counter and assembler
    logic              burst_start;
    logic              beat_accept;
    // counter back to fsm and assembler
    logic [BEAT_W-1:0] beat_idx;
    logic              last_beat;

    bridge_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .inst_req_i   (inst_req_i),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .arready_i    (arready_i),
        .rvalid_i     (rvalid_i),
        .awready_i    (awready_i),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .last_beat_i  (last_beat),
        .op_i         (latched_op),
        .capture_o    (capture),
        .grant_op_o   (grant_op),
        .arvalid_o    (arvalid_o),
        .rready_o     (rready_o),
        .awvalid_o    (awvalid_o),
        .wvalid_o     (wvalid_o),
        .bready_o     (bready_o),
        .burst_start_o(burst_start),
        .beat_accept_o(beat_accept),
        .inst_done_o  (inst_done_o),
        .data_done_o  (data_done_o)
    );

    // length comes from the latch, not from rlast
    beat_counter u_beat_counter (
        .clk        (clk),
        .reset      (reset),
        .clear_i    (burst_start),
        .beat_i     (beat_accept),
        .len_i      (arlen_o),
        .beat_idx_o (beat_idx),
        .last_beat_o(last_beat)
    );

    line_assembler u_line_assembler (
        .clk       (clk),
        .reset     (reset),
        .beat_i    (beat_accept),
        .beat_idx_i(beat_idx),
        .rdata_i   (rdata_i),
        .line_o    (inst_line_o),
        .word0_o   (data_rdata_o)
    );

    request_latch u_request_latch (
        .clk         (clk),
        .reset       (reset),
        .capture_i   (capture),
        .grant_op_i  (grant_op),
        .inst_addr_i (inst_addr_i),
        .data_addr_i (data_addr_i),
        .data_wdata_i(data_wdata_i),
        .data_wstrb_i(data_wstrb_i),
        .op_o        (latched_op),
        .araddr_o    (araddr_o),
        .arid_o      (arid_o),
        .arlen_o     (arlen_o),
        .awaddr_o    (awaddr_o),
        .wdata_o     (wdata_o),
        .wstrb_o     (wstrb_o)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset held for the first 10 rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                            clk,
    input  logic                            reset,
    // high selects long stalls on every channel
    input  logic                            heavy_i,
    // read address
    input  logic                            arvalid_i,
    output logic                            arready_o,
    input  logic [bridge_pkg::AXI_ID_W-1:0] arid_i,
    input  logic [bridge_pkg::ADDR_W-1:0]   araddr_i,
    input  logic [bridge_pkg::BEAT_W-1:0]   arlen_i,
    // read data
    output logic                            rvalid_o,
    input  logic                            rready_i,
    output logic [bridge_pkg::DATA_W-1:0]   rdata_o,
    // write address and data
    input  logic                            awvalid_i,
    output logic                            awready_o,
    input  logic [bridge_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic                            wvalid_i,
    output logic                            wready_o,
    input  logic [bridge_pkg::DATA_W-1:0]   wdata_i,
    input  logic [bridge_pkg::STRB_W-1:0]   wstrb_i,
    // write response
    output logic                            bvalid_o,
    input  logic                            bready_i,
    // fields of the last accepted read address
    output logic [bridge_pkg::AXI_ID_W-1:0] last_arid_o,
    output logic [bridge_pkg::BEAT_W-1:0]   last_arlen_o
);

    import bridge_pkg::*;

    localparam int MEM_WORDS = 256;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [31:0]       lfsr_q = 32'h25a3_5456;

    // read burst in progress
    logic              rd_active;
    logic [7:0]        rd_base;
    logic [BEAT_W-1:0] rd_len;
    logic [BEAT_W-1:0] rd_cnt;

    // write side collects aw and w in any order
    logic              aw_got;
    logic              w_got;
    logic              b_pending;
    logic [7:0]        wr_idx;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;

    // one draw per channel and cycle
    logic ar_go;
    logic r_go;
    logic aw_go;
    logic w_go;
    logic b_go;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // two bits, heavy means 1 in 4 cycles ready, light means 3 in 4
    function automatic logic pick_ready();
        logic b0;
        logic b1;
        lfsr_q = lfsr_next(lfsr_q);
        b0 = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        b1 = lfsr_q[0];
        return heavy_i ? (b0 & b1) : (b0 | b1);
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i * 32'h0101_0101 + 32'h1000;
        end
        arready_o    = 1'b0;
        rvalid_o     = 1'b0;
        rdata_o      = '0;
        awready_o    = 1'b0;
        wready_o     = 1'b0;
        bvalid_o     = 1'b0;
        last_arid_o  = '0;
        last_arlen_o = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            rd_active = 1'b0;
            rd_cnt    = '0;
            aw_got    = 1'b0;
            w_got     = 1'b0;
            b_pending = 1'b0;
        end else begin
            ar_go = pick_ready();
            r_go  = pick_ready();
            aw_go = pick_ready();
            w_go  = pick_ready();
            b_go  = pick_ready();

            // beat taken, burst ends after arlen+1 beats
            if (rvalid_o && rready_i) begin
                rd_cnt = rd_cnt + BEAT_W'(1);
                if (rd_cnt > rd_len) begin
                    rd_active = 1'b0;
                end
            end
            if (arvalid_i && arready_o) begin
                rd_base   = araddr_i[9:2];
                rd_len    = arlen_i;
                rd_cnt    = '0;
                rd_active = 1'b1;
                last_arid_o  <= arid_i;
                last_arlen_o <= arlen_i;
            end
            arready_o <= !rd_active && ar_go;
            // a pending beat holds its data until taken
            if (!rd_active) begin
                rvalid_o <= 1'b0;
            end else if (!rvalid_o || rready_i) begin
                rvalid_o <= r_go;
                rdata_o  <= mem[rd_base + rd_cnt[7:0]];
            end

            // response first, then new write payload
            if (bvalid_o && bready_i) begin
                b_pending = 1'b0;
                bvalid_o <= 1'b0;
            end else if (b_pending && !bvalid_o) begin
                bvalid_o <= b_go;
            end
            if (awvalid_i && awready_o) begin
                wr_idx = awaddr_i[9:2];
                aw_got = 1'b1;
            end
            if (wvalid_i && wready_o) begin
                wr_data = wdata_i;
                wr_strb = wstrb_i;
                w_got   = 1'b1;
            end
            if (aw_got && w_got) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_idx][b*8 +: 8] = wr_data[b*8 +: 8];
                    end
                end
                aw_got    = 1'b0;
                w_got     = 1'b0;
                b_pending = 1'b1;
            end
            awready_o <= !aw_got && !b_pending && aw_go;
            wready_o  <= !w_got && !b_pending && w_go;
        end
    end

endmodule

//--- tb/mem_bridge_tb.sv
`timescale 1ns/1ps

module mem_bridge_tb;

    import bridge_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
    // per request limit before a missing done is declared
    localparam int REQ_LIMIT       = 1000;
    localparam int RANDOM_REQS     = 20;

    logic clk;
    logic reset;
    logic heavy;

    // requester side
    logic                inst_req;
    logic [ADDR_W-1:0]   inst_addr;
    logic [LINE_W-1:0]   inst_line;
    logic                inst_done;
    logic                data_req;
    logic                data_we;
    logic [ADDR_W-1:0]   data_addr;
    logic [DATA_W-1:0]   data_wdata;
    logic [STRB_W-1:0]   data_wstrb;
    logic [DATA_W-1:0]   data_rdata;
    logic                data_done;

    // axi between dut and model
    logic                arvalid;
    logic                arready;
    logic [AXI_ID_W-1:0] arid;
    logic [ADDR_W-1:0]   araddr;
    logic [BEAT_W-1:0]   arlen;
    logic                rvalid;
    logic                rready;
    logic [DATA_W-1:0]   rdata;
    logic                awvalid;
    logic                awready;
    logic [ADDR_W-1:0]   awaddr;
    logic                wvalid;
    logic                wready;
    logic [DATA_W-1:0]   wdata;
    logic [STRB_W-1:0]   wstrb;
    logic                bvalid;
    logic                bready;
    logic [AXI_ID_W-1:0] last_arid;
    logic [BEAT_W-1:0]   last_arlen;

    // expected memory contents
    logic [DATA_W-1:0] shadow [256];
    logic [31:0]       lfsr_q = 32'h25a3_5456;
    int                errors;
    int                tests_run;
    int                tests_failed;

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    axi_mem_model u_mem (
        .clk(clk), .reset(reset), .heavy_i(heavy),
        .arvalid_i(arvalid), .arready_o(arready), .arid_i(arid),
        .araddr_i(araddr), .arlen_i(arlen),
        .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata),
        .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .bvalid_o(bvalid), .bready_i(bready),
        .last_arid_o(last_arid), .last_arlen_o(last_arlen)
    );

    mem_bridge_top uut (
        .clk(clk), .reset(reset),
        .inst_req_i(inst_req), .inst_addr_i(inst_addr),
        .inst_line_o(inst_line), .inst_done_o(inst_done),
        .data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
        .data_wdata_i(data_wdata), .data_wstrb_i(data_wstrb),
        .data_rdata_o(data_rdata), .data_done_o(data_done),
        .arvalid_o(arvalid), .arready_i(arready), .arid_o(arid),
        .araddr_o(araddr), .arlen_o(arlen),
        .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata),
        .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return idx * 32'h0101_0101 + 32'h1000;
    endfunction

    // fibonacci lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // four words from the line base, word 0 in the low bits
    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr);
        logic [7:0] base;
        base = {addr[9:4], 2'b00};
        return {shadow[base + 8'd3], shadow[base + 8'd2], shadow[base + 8'd1], shadow[base]};
    endfunction

    task automatic check(input string name, input logic [LINE_W-1:0] expected,
                         input logic [LINE_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // returns right after the edge that closes the done cycle
    task automatic wait_done(input logic inst_side);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < REQ_LIMIT && !seen; n++) begin
            @(posedge clk);
            seen = inst_side ? inst_done : data_done;
        end
        if (!seen) begin
            $display("ERROR t=%0t %s request got no done within %0d cycles", $time,
                     inst_side ? "instruction" : "data", REQ_LIMIT);
            errors++;
        end
    endtask

    task automatic inst_read(input logic [ADDR_W-1:0] addr, output logic [LINE_W-1:0] line);
        @(posedge clk);
        inst_req  <= 1'b1;
        inst_addr <= addr;
        wait_done(1'b1);
        inst_req <= 1'b0;
        line = inst_line;
    endtask

    task automatic data_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] word);
        @(posedge clk);
        data_req  <= 1'b1;
        data_we   <= 1'b0;
        data_addr <= addr;
        wait_done(1'b0);
        data_req <= 1'b0;
        word = data_rdata;
    endtask

    task automatic data_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] word,
                              input logic [STRB_W-1:0] strb);
        @(posedge clk);
        data_req   <= 1'b1;
        data_we    <= 1'b1;
        data_addr  <= addr;
        data_wdata <= word;
        data_wstrb <= strb;
        wait_done(1'b0);
        data_req <= 1'b0;
        data_we  <= 1'b0;
        shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], word, strb);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    // nothing may start without a request
    task automatic test_idle_quiet();
        int e0;
        e0 = errors;
        repeat (20) begin
            @(posedge clk);
            check("idle valids", '0, LINE_W'({arvalid, awvalid, wvalid, rready, bready,
                                              inst_done, data_done}));
        end
        end_test("idle_quiet", e0);
    endtask

    task automatic test_inst_line();
        int e0;
        logic [LINE_W-1:0] line;
        e0 = errors;
        // offset 8 inside the line at 0x140
        inst_read(32'h0000_0148, line);
        check("inst_line_o", expected_line(32'h0000_0148), line);
        check("arlen_o", LINE_W'(3), LINE_W'(last_arlen));
        check("arid_o", LINE_W'(ID_INST), LINE_W'(last_arid));
        end_test("inst_line", e0);
    endtask

    task automatic test_data_read();
        int e0;
        logic [DATA_W-1:0] word;
        e0 = errors;
        data_read(32'h0000_02c4, word);
        check("data_rdata_o", LINE_W'(shadow[8'hb1]), LINE_W'(word));
        check("arlen_o", LINE_W'(0), LINE_W'(last_arlen));
        check("arid_o", LINE_W'(ID_DATA), LINE_W'(last_arid));
        end_test("data_read", e0);
    endtask

    task automatic test_write_merge();
        int e0;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] merged;
        e0 = errors;
        // bytes 0 and 2 from new data, 1 and 3 from prior contents
        merged = merge_bytes(fill_word(32'h28), 32'hdead_beef, 4'b0101);
        data_write(32'h0000_00a0, 32'hdead_beef, 4'b0101);
        data_read(32'h0000_00a0, word);
        check("data_rdata_o", LINE_W'(merged), LINE_W'(word));
        end_test("write_merge", e0);
    endtask

    task automatic test_same_cycle();
        int e0;
        logic got_inst;
        logic got_data;
        logic data_first;
        logic [LINE_W-1:0] line;
        logic [DATA_W-1:0] word;
        e0 = errors;
        got_inst   = 1'b0;
        got_data   = 1'b0;
        data_first = 1'b0;
        @(posedge clk);
        inst_req  <= 1'b1;
        inst_addr <= 32'h0000_031c;
        data_req  <= 1'b1;
        data_we   <= 1'b0;
        data_addr <= 32'h0000_03f8;
        for (int n = 0; n < 2 * REQ_LIMIT && !(got_inst && got_data); n++) begin
            @(posedge clk);
            if (data_done && !got_data) begin
                got_data   = 1'b1;
                data_first = !got_inst;
                word       = data_rdata;
                data_req  <= 1'b0;
            end
            if (inst_done && !got_inst) begin
                got_inst  = 1'b1;
                line      = inst_line;
                inst_req <= 1'b0;
            end
        end
        if (!(got_inst && got_data)) begin
            $display("ERROR t=%0t simultaneous requests did not both complete", $time);
            errors++;
            inst_req <= 1'b0;
            data_req <= 1'b0;
        end else begin
            check("data before inst", LINE_W'(1'b1), LINE_W'(data_first));
            check("data_rdata_o", LINE_W'(shadow[8'hfe]), LINE_W'(word));
            check("inst_line_o", expected_line(32'h0000_031c), line);
        end
        end_test("same_cycle", e0);
    endtask

    task automatic test_random_mix();
        int e0;
        logic [1:0]        kind;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] word;
        logic [STRB_W-1:0] strb;
        logic [LINE_W-1:0] line;
        e0 = errors;
        heavy <= 1'b1;
        for (int k = 0; k < RANDOM_REQS; k++) begin
            kind = 2'(take_bits(2));
            addr = take_bits(10);
            if (kind == 2'd0) begin
                inst_read(addr, line);
                check("inst_line_o", expected_line(addr), line);
            end else if (kind == 2'd1) begin
                data_read({addr[31:2], 2'b00}, word);
                check("data_rdata_o", LINE_W'(shadow[addr[9:2]]), LINE_W'(word));
            end else begin
                word = take_bits(32);
                strb = STRB_W'(take_bits(4));
                data_write({addr[31:2], 2'b00}, word, strb);
            end
        end
        heavy <= 1'b0;
        end_test("random_mix", e0);
    endtask

    initial begin
        inst_req     = 1'b0;
        inst_addr    = '0;
        data_req     = 1'b0;
        data_we      = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        data_wstrb   = '0;
        heavy        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(i);
        end
        // reset may still be unknown at time zero
        while (reset !== 1'b0) begin
            @(posedge clk);
        end

        test_idle_quiet();
        test_inst_line();
        test_data_read();
        test_write_merge();
        test_same_cycle();
        test_random_mix();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run == NUM_TESTS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // bound on total run time
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- project.f
source/bridge_pkg.sv
source/beat_counter.sv
source/line_assembler.sv
source/request_latch.sv
source/bridge_fsm.sv
source/mem_bridge_top.sv
tb/tb_clock_gen.sv
tb/axi_mem_model.sv
tb/mem_bridge_tb.sv

//--- Makefile
TOOL   := verilator
FLAGS  := --binary --timing -j 0
TOP    := mem_bridge_tb
FLIST  := project.f
BUILD  := obj_dir
LOG    := sim.log
PASS   := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
